// ==== bench/mem_xlate_assertions.sv ====
`timescale 1ns/1ps

module mem_xlate_assertions (
    input logic        clk,
    input logic        rst,
    input logic        out_valid,
    input logic        out_exc,
    input logic        out_refill,
    input logic [3:0]  out_wstrb,
    input logic [31:0] out_paddr
);

    int fail_cnt = 0;

    a_no_strobe_on_exc: assert property (@(posedge clk) disable iff (rst)
        (out_valid && out_exc) |-> (out_wstrb == 4'b0000))
        else begin
            $error("write strobe active on a faulting access");
            fail_cnt++;
        end

    a_refill_has_exc: assert property (@(posedge clk) disable iff (rst)
        (out_valid && out_refill) |-> out_exc)
        else begin
            $error("refill flagged without an exception");
            fail_cnt++;
        end

    a_idle_after_reset: assert property (@(posedge clk) rst |=> !out_valid)
        else begin
            $error("out_valid high right after reset");
            fail_cnt++;
        end

    a_no_paddr_on_exc: assert property (@(posedge clk) disable iff (rst)
        (out_valid && out_exc) |-> (out_paddr == 32'h0))
        else begin
            $error("physical address leaked on a faulting access");
            fail_cnt++;
        end

endmodule

bind mem_xlate_top mem_xlate_assertions u_assert (
    .clk        (clk),
    .rst        (rst),
    .out_valid  (out_valid),
    .out_exc    (out_exc),
    .out_refill (out_refill),
    .out_wstrb  (out_wstrb),
    .out_paddr  (out_paddr)
);

// ==== bench/mem_xlate_tb.sv ====
`timescale 1ns/1ps

module mem_xlate_tb
    import mem_xlate_pkg::*;
();

    typedef struct {
        byte         kind;   // W, R, F, or I for a drain cycle
        logic        live;   // result must come out
        logic [2:0]  idx;
        logic [19:0] vpn;
        logic [19:0] pfn;
        logic        v;
        logic        d;
        logic [3:0]  op;
        logic [31:0] vaddr;
        logic [31:0] rt;
        logic [31:0] paddr;
        logic        uncached;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
        logic        exc;
        exc_code_t   exc_code;
        logic        refill;
        logic [31:0] badvaddr;
    } vec_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        flush;
    logic        req_valid;
    mem_op_e     req_op;
    vaddr_t      req_vaddr;
    logic [31:0] req_rt_data;
    logic        tlb_we;
    logic [2:0]  tlb_idx;
    tlb_entry_t  tlb_wentry;
    logic        out_valid;
    logic [31:0] out_paddr;
    logic        out_uncached;
    logic [3:0]  out_wstrb;
    logic [31:0] out_wdata;
    logic        out_exc;
    exc_code_t   out_exc_code;
    logic        out_refill;
    logic [31:0] out_badvaddr;

    vec_t vecs[$];
    vec_t exp_q[$];   // one entry per driven cycle
    vec_t idle;
    int   n_vec;
    bit   loaded;
    int   seed = 32'hfa25_e4ac;
    int   value_errs;
    int   valid_errs;
    int   file_errs;

    mem_xlate_top #(.TLB_ENTRIES(8)) DUT (.*);

    always #5 clk = ~clk;

    task automatic read_vectors();
        int   fd;
        int   c;
        int   r;
        int   n_fields;
        byte  ch;
        vec_t vec;
        fd = $fopen("bench/mem_xlate_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open bench/mem_xlate_vectors.txt");
            file_errs++;
            return;
        end
        c = $fgetc(fd);
        while (c != -1) begin
            ch = 8'(c);
            if (ch == "#") begin
                while (c != -1 && 8'(c) != "\n") begin
                    c = $fgetc(fd);
                end
            end else if (ch == "W" || ch == "R" || ch == "F") begin
                vec.kind = ch;
                vec.live = (ch == "R");
                if (ch == "W") begin
                    r = $fscanf(fd, "%h %h %h %h %h", vec.idx, vec.vpn, vec.pfn, vec.v, vec.d);
                    n_fields = 5;
                end else begin
                    r = $fscanf(fd, "%h %h %h", vec.op, vec.vaddr, vec.rt);
                    n_fields = 3;
                end
                if (ch == "R") begin
                    r += $fscanf(fd, "%h %h %h %h %h %h %h %h", vec.paddr, vec.uncached,
                                 vec.wstrb, vec.wdata, vec.exc, vec.exc_code, vec.refill,
                                 vec.badvaddr);
                    n_fields += 8;
                end
                if (r != n_fields) begin
                    $display("vector line of kind %c has %0d of %0d fields", ch, r, n_fields);
                    file_errs++;
                end
                vecs.push_back(vec);
            end
            c = $fgetc(fd);
        end
        $fclose(fd);
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("** Error: %s expected %08h got %08h", name, exp, act);
            value_errs++;
        end
    endtask

    task automatic check_strobe(input string name, input logic [3:0] exp, input logic [3:0] act);
        if (act !== exp) begin
            $display("** Error: %s expected %h got %h", name, exp, act);
            value_errs++;
        end
    endtask

    task automatic check_exc(input string name, input exc_code_t exp, input exc_code_t act);
        if (act !== exp) begin
            $display("** Error: %s expected %02h got %02h", name, exp, act);
            value_errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error: %s expected %h got %h", name, exp, act);
            value_errs++;
        end
    endtask

    task automatic compare_output(input vec_t exp);
        if (!exp.live) begin
            if (out_valid !== 1'b0) begin
                $display("out_valid went high with no request due in this cycle");
                valid_errs++;
            end
        end else if (out_valid !== 1'b1) begin
            $display("out_valid missing for the request to address %08h", exp.vaddr);
            valid_errs++;
        end else begin
            check_word("out_paddr", exp.paddr, out_paddr);
            check_flag("out_uncached", exp.uncached, out_uncached);
            check_strobe("out_wstrb", exp.wstrb, out_wstrb);
            check_word("out_wdata", exp.wdata, out_wdata);
            check_flag("out_exc", exp.exc, out_exc);
            check_exc("out_exc_code", exp.exc_code, out_exc_code);
            check_flag("out_refill", exp.refill, out_refill);
            check_word("out_badvaddr", exp.badvaddr, out_badvaddr);
        end
    endtask

    // one cycle per vector, result checked 3 drive edges later
    task automatic apply_vector(input vec_t vec);
        @(posedge clk);
        req_valid <= (vec.kind == "R") || (vec.kind == "F");
        flush     <= (vec.kind == "F");
        tlb_we    <= (vec.kind == "W");
        if (vec.kind == "W") begin
            tlb_idx    <= vec.idx;
            tlb_wentry <= {vec.vpn, vec.pfn, vec.v, vec.d};
        end
        if (vec.kind == "R" || vec.kind == "F") begin
            req_op      <= mem_op_e'(vec.op);
            req_vaddr   <= vec.vaddr;
            req_rt_data <= vec.rt;
        end else begin
            req_vaddr   <= $random(seed);   // noise while idle
            req_rt_data <= $random(seed);
        end
        if (vec.kind == "F") begin
            for (int i = 1; i <= 2 && i <= exp_q.size(); i++) begin
                exp_q[exp_q.size() - i].live = 1'b0;
            end
        end
        exp_q.push_back(vec);
        @(negedge clk);
        if (exp_q.size() == 4) begin
            compare_output(exp_q.pop_front());
        end else if (out_valid !== 1'b0) begin
            $display("out_valid went high before any request could finish");
            valid_errs++;
        end
    endtask

    initial begin
        rst         = 1'b1;
        flush       = 1'b0;
        req_valid   = 1'b0;
        req_op      = OP_LB;
        req_vaddr   = '0;
        req_rt_data = '0;
        tlb_we      = 1'b0;
        tlb_idx     = '0;
        tlb_wentry  = '0;
        idle.kind   = "I";
        idle.live   = 1'b0;
        read_vectors();
        n_vec  = vecs.size();
        loaded = 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        foreach (vecs[i]) apply_vector(vecs[i]);
        repeat (3) apply_vector(idle);   // drain the pipe
        $display("errors: value %0d, valid %0d, assertion %0d, file %0d",
                 value_errs, valid_errs, DUT.u_assert.fail_cnt, file_errs);
        if (value_errs + valid_errs + DUT.u_assert.fail_cnt + file_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        wait (loaded);
        #((n_vec + 20) * 10);
        $display("watchdog expired before all vectors were checked");
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== bench/mem_xlate_vectors.txt ====
# W idx vpn pfn v d | F op vaddr rt (flush, request dropped)
# R op vaddr rt paddr uncached wstrb wdata exc exc_code refill badvaddr
R 4 80001000 11223344 00001000 0 0 11223344 0 0 0 00000000
R 7 a0002004 cafef00d 00002004 1 f cafef00d 0 0 0 00000000
R 1 a0000013 0000005a 00000013 1 0 0000005a 0 0 0 00000000
W 0 00400 12345 1 1
W 1 00401 0abcd 1 0
W 2 00402 00777 0 0
R 4 00400ab8 00000000 12345ab8 0 0 00000000 0 0 0 00000000
W 3 7ffff 00fff 1 1
R 7 7ffff010 deadbeef 00fff010 0 f deadbeef 0 0 0 00000000
R 4 80000102 00000000 00000000 0 0 00000000 1 4 0 80000102
R 6 12345001 00005555 00000000 0 0 00005555 1 5 0 12345001
R 4 12345678 00000000 00000000 0 0 00000000 1 2 1 12345678
R 5 00500003 000000aa 00000000 0 0 000000aa 1 3 1 00500003
R 0 00402010 00000000 00000000 0 0 00000000 1 2 0 00402010
R 7 00402000 87654321 00000000 0 0 87654321 1 3 0 00402000
R 7 00401008 13572468 00000000 0 0 13572468 1 1 0 00401008
R 2 00401006 00000000 0abcd006 0 0 00000000 0 0 0 00000000
R 5 80000000 11223344 00000000 0 1 44444444 0 0 0 00000000
R 5 80000001 11223344 00000001 0 2 44444444 0 0 0 00000000
R 5 80000002 11223344 00000002 0 4 44444444 0 0 0 00000000
R 5 80000003 11223344 00000003 0 8 44444444 0 0 0 00000000
R 6 80000010 11223344 00000010 0 3 33443344 0 0 0 00000000
R 6 80000012 11223344 00000012 0 c 33443344 0 0 0 00000000
R 8 80000020 11223344 00000020 0 1 11111111 0 0 0 00000000
R 8 80000021 11223344 00000021 0 3 11221122 0 0 0 00000000
R 8 80000022 11223344 00000022 0 7 00112233 0 0 0 00000000
R 8 80000023 11223344 00000023 0 f 11223344 0 0 0 00000000
R 9 80000030 11223344 00000030 0 f 11223344 0 0 0 00000000
R 9 80000031 11223344 00000031 0 e 22334400 0 0 0 00000000
R 9 80000032 11223344 00000032 0 c 33443344 0 0 0 00000000
R 9 80000033 11223344 00000033 0 8 44444444 0 0 0 00000000
R 4 80000040 00000000 00000040 0 0 00000000 0 0 0 00000000
R 4 80000044 00000000 00000044 0 0 00000000 0 0 0 00000000
R 4 80000048 00000000 00000048 0 0 00000000 0 0 0 00000000
F 4 8000004c 00000000
R 4 00400ffc 00000000 12345ffc 0 0 00000000 0 0 0 00000000

// ==== design/access_check_stage.sv ====
`timescale 1ns/1ps

module access_check_stage
    import mem_xlate_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      flush,
    tlb_result_if.dst res,
    access_if.src     acc
);

    logic        unmapped;
    logic        store;
    logic        misaligned;
    logic [31:0] paddr_map;
    logic        exc_n;
    exc_code_t   exc_code_n;
    logic        refill_n;

    // kseg0 and kseg1 bypass the table
    assign unmapped  = (res.vaddr.seg.seg[2:1] == 2'b10);
    assign store     = is_store(res.op);
    assign paddr_map = unmapped ? {3'b000, res.vaddr.seg.seg_off}
                                : {res.pfn, res.vaddr.page.page_off};

    always_comb begin
        misaligned = 1'b0;
        case (res.op)
            OP_LW, OP_SW:         misaligned = (res.vaddr.page.page_off[1:0] != 2'b00);
            OP_LH, OP_LHU, OP_SH: misaligned = res.vaddr.page.page_off[0];
            default:              misaligned = 1'b0;   // bytes, swl, swr
        endcase
    end

    // address error first, then tlb miss/invalid, then mod
    always_comb begin
        exc_n      = 1'b1;
        exc_code_n = EXC_NONE;
        refill_n   = 1'b0;
        if (misaligned) begin
            exc_code_n = store ? EXC_ADES : EXC_ADEL;
        end else if (!unmapped && (!res.found || !res.v)) begin
            exc_code_n = store ? EXC_TLBS : EXC_TLBL;
            refill_n   = ~res.found;
        end else if (!unmapped && store && !res.d) begin
            exc_code_n = EXC_MOD;
        end else begin
            exc_n = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc.valid <= 1'b0;
        end else begin
            acc.valid <= res.valid & ~flush;
        end
    end

    always_ff @(posedge clk) begin
        acc.op       <= res.op;
        acc.rt_data  <= res.rt_data;
        acc.uncached <= unmapped & res.vaddr.seg.seg[0];   // kseg1
        acc.exc      <= exc_n;
        acc.exc_code <= exc_code_n;
        acc.refill   <= refill_n;
        acc.paddr    <= exc_n ? 32'h0 : paddr_map;
        acc.badvaddr <= exc_n ? res.vaddr : 32'h0;
    end

endmodule

// ==== design/access_if.sv ====
`timescale 1ns/1ps

// checked physical access, stage 2 to stage 3
interface access_if
    import mem_xlate_pkg::*;
();
    logic        valid;
    mem_op_e     op;
    logic [31:0] paddr;
    logic        uncached;
    logic [31:0] rt_data;
    logic        exc;
    exc_code_t   exc_code;
    logic        refill;
    logic [31:0] badvaddr;

    modport src (
        output valid, op, paddr, uncached, rt_data, exc, exc_code, refill, badvaddr
    );
    modport dst (
        input valid, op, paddr, uncached, rt_data, exc, exc_code, refill, badvaddr
    );

endinterface

// ==== design/mem_xlate_pkg.sv ====
package mem_xlate_pkg;

    // one virtual address word, decoded by segment or by page
    typedef struct packed {
        logic [2:0]  seg;
        logic [28:0] seg_off;
    } seg_view_t;

    typedef struct packed {
        logic [19:0] vpn;
        logic [11:0] page_off;
    } page_view_t;

    typedef union packed {
        seg_view_t  seg;
        page_view_t page;
    } vaddr_t;

    typedef enum logic [3:0] {
        OP_LB,
        OP_LBU,
        OP_LH,
        OP_LHU,
        OP_LW,
        OP_SB,
        OP_SH,
        OP_SW,
        OP_SWL,
        OP_SWR
    } mem_op_e;

    typedef logic [4:0] exc_code_t;

    localparam exc_code_t EXC_NONE = 5'd0;
    localparam exc_code_t EXC_MOD  = 5'd1;
    localparam exc_code_t EXC_TLBL = 5'd2;
    localparam exc_code_t EXC_TLBS = 5'd3;
    localparam exc_code_t EXC_ADEL = 5'd4;
    localparam exc_code_t EXC_ADES = 5'd5;

    typedef struct packed {
        logic [19:0] vpn;
        logic [19:0] pfn;
        logic        v;   // page valid
        logic        d;   // dirty, store allowed
    } tlb_entry_t;

    function automatic logic is_store(input mem_op_e op);
        return op inside {OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR};
    endfunction

endpackage

// ==== design/mem_xlate_top.sv ====
`timescale 1ns/1ps

module mem_xlate_top
    import mem_xlate_pkg::*;
#(
    parameter int TLB_ENTRIES = 8,
    localparam int IDX_W = $clog2(TLB_ENTRIES)
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             flush,
    input  logic             req_valid,
    input  mem_op_e          req_op,
    input  vaddr_t           req_vaddr,
    input  logic [31:0]      req_rt_data,
    input  logic             tlb_we,
    input  logic [IDX_W-1:0] tlb_idx,
    input  tlb_entry_t       tlb_wentry,
    output logic             out_valid,
    output logic [31:0]      out_paddr,
    output logic             out_uncached,
    output logic [3:0]       out_wstrb,
    output logic [31:0]      out_wdata,
    output logic             out_exc,
    output exc_code_t        out_exc_code,
    output logic             out_refill,
    output logic [31:0]      out_badvaddr
);

    tlb_result_if res_if ();
    access_if     acc_if ();

    tlb_lookup_stage #(
        .TLB_ENTRIES(TLB_ENTRIES)
    ) u_lookup (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .req_valid   (req_valid),
        .req_op      (req_op),
        .req_vaddr   (req_vaddr),
        .req_rt_data (req_rt_data),
        .tlb_we      (tlb_we),
        .tlb_idx     (tlb_idx),
        .tlb_wentry  (tlb_wentry),
        .res         (res_if.src)
    );

    access_check_stage u_check (
        .clk   (clk),
        .rst   (rst),
        .flush (flush),
        .res   (res_if.dst),
        .acc   (acc_if.src)
    );

    store_lane_stage u_lane (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .acc          (acc_if.dst),
        .out_valid    (out_valid),
        .out_paddr    (out_paddr),
        .out_uncached (out_uncached),
        .out_wstrb    (out_wstrb),
        .out_wdata    (out_wdata),
        .out_exc      (out_exc),
        .out_exc_code (out_exc_code),
        .out_refill   (out_refill),
        .out_badvaddr (out_badvaddr)
    );

endmodule

// ==== design/store_lane_stage.sv ====
`timescale 1ns/1ps

module store_lane_stage
    import mem_xlate_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    access_if.dst       acc,
    output logic        out_valid,
    output logic [31:0] out_paddr,
    output logic        out_uncached,
    output logic [3:0]  out_wstrb,
    output logic [31:0] out_wdata,
    output logic        out_exc,
    output exc_code_t   out_exc_code,
    output logic        out_refill,
    output logic [31:0] out_badvaddr
);

    logic [1:0]  off;
    logic [31:0] rt;
    logic [3:0]  wstrb_n;
    logic [31:0] wdata_n;

    assign off = acc.paddr[1:0];
    assign rt  = acc.rt_data;

    always_comb begin
        wstrb_n = 4'b0000;
        wdata_n = rt;   // loads pass rt through
        if (is_store(acc.op) && !acc.exc) begin
            case (acc.op)
                OP_SB: begin
                    wstrb_n = 4'b0001 << off;
                    wdata_n = {4{rt[7:0]}};
                end
                OP_SH: begin
                    wstrb_n = off[1] ? 4'b1100 : 4'b0011;
                    wdata_n = {2{rt[15:0]}};
                end
                OP_SWL: begin
                    case (off)
                        2'd0:    begin wstrb_n = 4'b0001; wdata_n = {4{rt[31:24]}}; end
                        2'd1:    begin wstrb_n = 4'b0011; wdata_n = {2{rt[31:16]}}; end
                        2'd2:    begin wstrb_n = 4'b0111; wdata_n = {8'h00, rt[31:8]}; end
                        default: wstrb_n = 4'b1111;
                    endcase
                end
                OP_SWR: begin
                    case (off)
                        2'd1:    begin wstrb_n = 4'b1110; wdata_n = {rt[23:0], 8'h00}; end
                        2'd2:    begin wstrb_n = 4'b1100; wdata_n = {2{rt[15:0]}}; end
                        2'd3:    begin wstrb_n = 4'b1000; wdata_n = {4{rt[7:0]}}; end
                        default: wstrb_n = 4'b1111;
                    endcase
                end
                default: wstrb_n = 4'b1111;   // sw
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= acc.valid & ~flush;
        end
    end

    always_ff @(posedge clk) begin
        out_paddr    <= acc.paddr;
        out_uncached <= acc.uncached;
        out_wstrb    <= wstrb_n;
        out_wdata    <= wdata_n;
        out_exc      <= acc.exc;
        out_exc_code <= acc.exc_code;
        out_refill   <= acc.refill;
        out_badvaddr <= acc.badvaddr;
    end

endmodule

// ==== design/tlb_lookup_stage.sv ====
`timescale 1ns/1ps

module tlb_lookup_stage
    import mem_xlate_pkg::*;
#(
    parameter int TLB_ENTRIES = 8,
    localparam int IDX_W = $clog2(TLB_ENTRIES)
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             flush,
    input  logic             req_valid,
    input  mem_op_e          req_op,
    input  vaddr_t           req_vaddr,
    input  logic [31:0]      req_rt_data,
    input  logic             tlb_we,
    input  logic [IDX_W-1:0] tlb_idx,
    input  tlb_entry_t       tlb_wentry,
    tlb_result_if.src        res
);

    tlb_entry_t tlb_q [TLB_ENTRIES];

    logic       hit;
    tlb_entry_t hit_entry;

    // fill port, entries survive flush
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                tlb_q[i] <= '0;
            end
        end else if (tlb_we) begin
            tlb_q[tlb_idx] <= tlb_wentry;
        end
    end

    // scan downwards so the lowest index wins
    always_comb begin
        hit       = 1'b0;
        hit_entry = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (tlb_q[i].vpn == req_vaddr.page.vpn) begin
                hit       = 1'b1;
                hit_entry = tlb_q[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res.valid <= 1'b0;
        end else begin
            res.valid <= req_valid & ~flush;
        end
    end

    always_ff @(posedge clk) begin
        res.op      <= req_op;
        res.vaddr   <= req_vaddr;
        res.rt_data <= req_rt_data;
        res.found   <= hit;
        res.v       <= hit_entry.v;
        res.d       <= hit_entry.d;
        res.pfn     <= hit_entry.pfn;
    end

endmodule

// ==== design/tlb_result_if.sv ====
`timescale 1ns/1ps

// request plus lookup result, stage 1 to stage 2
interface tlb_result_if
    import mem_xlate_pkg::*;
();
    logic        valid;
    mem_op_e     op;
    vaddr_t      vaddr;
    logic [31:0] rt_data;
    logic        found;
    logic        v;
    logic        d;
    logic [19:0] pfn;

    modport src (
        output valid, op, vaddr, rt_data, found, v, d, pfn
    );
    modport dst (
        input valid, op, vaddr, rt_data, found, v, d, pfn
    );

endinterface

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f verilog.f --top-module mem_xlate_tb -o mem_xlate_sim
./obj_dir/mem_xlate_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
exit 0

// ==== verilog.f ====
design/mem_xlate_pkg.sv
design/tlb_result_if.sv
design/access_if.sv
design/tlb_lookup_stage.sv
design/access_check_stage.sv
design/store_lane_stage.sv
design/mem_xlate_top.sv
bench/mem_xlate_assertions.sv
bench/mem_xlate_tb.sv
